//--- logic/pdp8_pkg.sv
`default_nettype none

package pdp8_pkg;

  localparam int WORD_W = 12;

  // bit 0 is the msb, as in the PDP-8 manuals
  typedef logic [0:WORD_W-1] word_t;

  typedef enum logic [2:0] {
    OP_AND, OP_TAD, OP_ISZ, OP_DCA, OP_JMS, OP_JMP, OP_IOT, OP_OPR
  } opcode_e;

  localparam int IND_BIT  = 3;
  localparam int PAGE_BIT = 4;
  localparam int CLA_BIT  = 4;
  localparam int CMA_BIT  = 6;
  localparam int IAC_BIT  = 11;

  localparam word_t NOP_WORD = 12'o7000;
  localparam word_t HLT_WORD = 12'o7402;

  typedef enum logic [4:0] {
    IDLE, F0, FW, F3, D0, DW, D1, DW1, E0, EW, E1, E2, H0, HW, H1, H2, RT
  } major_state_e;

  typedef enum logic [2:0] {NONE, LOAD_ADDR, DEPOSIT, EXAMINE, START} panel_op_e;

  typedef struct packed {
    panel_op_e op;
    word_t     data;
  } panel_cmd_t;

  typedef struct packed {
    word_t instruction;
    word_t ma;
    word_t mdout;
    logic  isz_skip;
  } mau_out_t;

  // pointers at 0010-0017 step before use
  function automatic logic is_auto_index(word_t addr);
    return addr[0:WORD_W-4] == (WORD_W-3)'(1);
  endfunction

endpackage

`default_nettype wire

//--- logic/host_bus_pkg.sv
`default_nettype none

package host_bus_pkg;

  localparam int WB_DAT_W = 16;

  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [1:0]          adr;
    logic [WB_DAT_W-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic                ack;
    logic [WB_DAT_W-1:0] dat;
  } wb_rsp_t;

  localparam logic [1:0] REG_MA     = 2'd0;
  localparam logic [1:0] REG_MD     = 2'd1;
  localparam logic [1:0] REG_RUN    = 2'd2;
  localparam logic [1:0] REG_STATUS = 2'd3;

  localparam int STATUS_RUN_BIT = 15;  // link sits just above ac

  typedef struct packed {
    pdp8_pkg::word_t pc;  // address the instruction was fetched from
    pdp8_pkg::word_t instruction;
    pdp8_pkg::word_t ac;
    logic            link;
    pdp8_pkg::word_t ma;
    pdp8_pkg::word_t mdout;
  } retire_t;

endpackage

`default_nettype wire

//--- logic/wb_host_port.sv
`default_nettype none

module wb_host_port #(
  parameter int WORD_W = pdp8_pkg::WORD_W
) (
  input  logic                  clk,
  input  logic                  reset,
  input  host_bus_pkg::wb_req_t wb_req,
  output host_bus_pkg::wb_rsp_t wb_rsp,
  input  logic                  running,
  input  logic                  link,
  input  pdp8_pkg::word_t       ac,
  output pdp8_pkg::panel_cmd_t  cmd,
  output logic                  cmd_valid,
  input  logic                  cmd_done,
  input  pdp8_pkg::word_t       panel_data
);
  import pdp8_pkg::*;
  import host_bus_pkg::*;

  logic                ack_q;
  logic [WB_DAT_W-1:0] dat_q;
  logic [WB_DAT_W-1:0] status_word;
  logic                new_req;
  panel_op_e           req_op;

  // no new transfer while acking or while a command is out
  assign new_req = wb_req.cyc && wb_req.stb && !ack_q && !cmd_valid;

  always_comb begin
    status_word = '0;
    status_word[STATUS_RUN_BIT] = running;
    status_word[WORD_W] = link;
    status_word[WORD_W-1:0] = ac;
  end

  // panel is locked out while the processor runs
  always_comb begin
    req_op = NONE;
    if (!running) begin
      case (wb_req.adr)
        REG_MA:  if (wb_req.we) req_op = LOAD_ADDR;
        REG_MD:  req_op = wb_req.we ? DEPOSIT : EXAMINE;
        REG_RUN: if (wb_req.we) req_op = START;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ack_q     <= 1'b0;
      cmd_valid <= 1'b0;
      cmd       <= '{op: NONE, data: '0};
    end else begin
      ack_q <= 1'b0;
      if (cmd_valid && cmd_done) begin
        cmd_valid <= 1'b0;
        ack_q     <= 1'b1;
      end else if (new_req) begin
        if (req_op == NONE) begin
          ack_q <= 1'b1;  // status or ignored access
        end else begin
          cmd_valid <= 1'b1;
          cmd       <= '{op: req_op, data: wb_req.dat[WORD_W-1:0]};
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid && cmd_done) dat_q <= WB_DAT_W'(panel_data);
    else if (new_req) dat_q <= (wb_req.adr == REG_STATUS) ? status_word : '0;
  end

  assign wb_rsp = '{ack: ack_q, dat: dat_q};

  a_ack_single: assert property (@(posedge clk) disable iff (reset)
    wb_rsp.ack |=> !wb_rsp.ack);

endmodule

`default_nettype wire

//--- logic/major_state_seq.sv
`default_nettype none

module major_state_seq #(
  parameter int WORD_W = pdp8_pkg::WORD_W
) (
  input  logic                   clk,
  input  logic                   reset,
  input  pdp8_pkg::panel_cmd_t   cmd,
  input  logic                   cmd_valid,
  output logic                   cmd_done,
  output pdp8_pkg::word_t        panel_data,
  input  pdp8_pkg::mau_out_t     mau,
  output pdp8_pkg::major_state_e state,
  output pdp8_pkg::word_t        pc,
  output pdp8_pkg::word_t        ac,
  output logic                   link,
  output logic                   running,
  output host_bus_pkg::retire_t  rec,
  output logic                   rec_push,
  input  logic                   full
);
  import pdp8_pkg::*;

  word_t   fetch_pc;
  opcode_e op;
  logic    indirect;
  logic    halt;

  function automatic logic [WORD_W:0] opr_group1(word_t ir, logic l_in, word_t a_in);
    logic [WORD_W:0] la;
    la = {l_in, a_in};
    if (ir[CLA_BIT]) la[WORD_W-1:0] = '0;
    if (ir[CMA_BIT]) la[WORD_W-1:0] = ~la[WORD_W-1:0];
    if (ir[IAC_BIT]) la = la + 1'b1;  // carry flips link
    return la;
  endfunction

  assign op       = opcode_e'(mau.instruction[0:2]);
  assign indirect = mau.instruction[IND_BIT];
  assign halt     = (mau.instruction == HLT_WORD);

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= IDLE;
      pc       <= '0;
      ac       <= '0;
      link     <= 1'b0;
      running  <= 1'b0;
      fetch_pc <= '0;
    end else begin
      case (state)
        IDLE: if (cmd_valid) state <= H0;
        H0:   state <= HW;
        HW:   state <= H1;
        H1:   state <= H2;
        H2: begin
          if (cmd.op == START) begin
            pc      <= cmd.data;
            running <= 1'b1;
            state   <= F0;
          end else begin
            state <= IDLE;
          end
        end
        F0: begin
          fetch_pc <= pc;
          state    <= FW;
        end
        FW: state <= F3;
        F3: begin
          pc <= pc + 1'b1;
          if (op == OP_OPR && !indirect) {link, ac} <= opr_group1(mau.instruction, link, ac);
          if (op == OP_IOT || op == OP_OPR || (op == OP_JMP && !indirect)) state <= RT;
          else if (indirect) state <= D0;
          else state <= E0;
        end
        D0: state <= DW;
        DW: state <= D1;
        D1: begin
          if (is_auto_index(mau.ma)) state <= DW1;
          else state <= (op == OP_JMP) ? RT : E0;
        end
        DW1: state <= (op == OP_JMP) ? RT : E0;
        E0:  state <= EW;
        EW:  state <= E1;
        E1: begin
          if (op == OP_AND) ac <= ac & mau.mdout;
          if (op == OP_TAD) {link, ac} <= {link, ac} + {1'b0, mau.mdout};
          state <= E2;
        end
        E2: begin
          if (op == OP_DCA) ac <= '0;
          state <= RT;
        end
        RT: if (!full) begin  // hold here under back-pressure
          case (op)
            OP_JMP:  pc <= mau.ma;
            OP_JMS:  pc <= mau.ma + 1'b1;
            OP_ISZ:  if (mau.isz_skip) pc <= pc + 1'b1;
            default: ;
          endcase
          if (halt) begin
            running <= 1'b0;
            state   <= IDLE;
          end else begin
            state <= F0;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign cmd_done   = (state == H2);
  assign panel_data = mau.mdout;
  assign rec_push   = (state == RT) && !full;

  assign rec = '{pc: fetch_pc, instruction: mau.instruction, ac: ac, link: link,
                 ma: mau.ma, mdout: mau.mdout};

  // tracer must report full right after taking a record
  a_push_fills: assert property (@(posedge clk) disable iff (reset)
    rec_push |=> full);

endmodule

`default_nettype wire

//--- logic/mem_address_unit.sv
`default_nettype none

module mem_address_unit #(
  parameter int WORD_W = pdp8_pkg::WORD_W
) (
  input  logic                   clk,
  input  logic                   reset,
  input  pdp8_pkg::major_state_e state,
  input  pdp8_pkg::word_t        pc,
  input  pdp8_pkg::word_t        ac,
  input  pdp8_pkg::panel_cmd_t   cmd,
  output pdp8_pkg::mau_out_t     mau,
  output pdp8_pkg::word_t        mem_addr,
  output pdp8_pkg::word_t        mem_wdata,
  output logic                   mem_we,
  input  pdp8_pkg::word_t        mem_rdata
);
  import pdp8_pkg::*;

  localparam int PAGE_W = WORD_W - 7;  // 128-word pages

  word_t             ma;
  word_t             instruction;
  word_t             mdout;
  word_t             mdin;
  logic [0:PAGE_W-1] current_page;
  logic              isz_skip;
  logic              write_en;
  word_t             eff_addr;
  opcode_e           op;

  assign op = opcode_e'(instruction[0:2]);

  assign eff_addr = {(instruction[PAGE_BIT] ? current_page : {PAGE_W{1'b0}}),
                     instruction[PAGE_W:WORD_W-1]};

  // address mux
  always_comb begin
    case (state)
      F0:      mem_addr = pc;
      default: mem_addr = ma;  // pointers, operands and panel all go through ma
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ma           <= '0;
      instruction  <= NOP_WORD;
      current_page <= '0;
      isz_skip     <= 1'b0;
      write_en     <= 1'b0;
    end else begin
      write_en <= 1'b0;
      case (state)
        F0: begin
          current_page <= pc[0:PAGE_W-1];
          isz_skip     <= 1'b0;
        end
        FW: instruction <= mem_rdata;
        F3: if (op != OP_IOT && op != OP_OPR) ma <= eff_addr;
        D1: begin
          if (is_auto_index(ma)) write_en <= 1'b1;  // write back stepped pointer
          else ma <= mdout;
        end
        DW1: ma <= mdin;
        E1: begin
          if (op == OP_ISZ || op == OP_JMS || op == OP_DCA) write_en <= 1'b1;
          if (op == OP_ISZ) isz_skip <= (mdout == '1);  // 7777 wraps to 0000
        end
        H1: begin
          if (cmd.op == LOAD_ADDR) ma <= cmd.data;
          if (cmd.op == DEPOSIT) write_en <= 1'b1;
        end
        H2: if (cmd.op == DEPOSIT || cmd.op == EXAMINE) ma <= ma + 1'b1;
        default: ;
      endcase
    end
  end

  // memory data registers
  always_ff @(posedge clk) begin
    case (state)
      FW, DW, EW, HW: mdout <= mem_rdata;
      D1: mdin <= mdout + 1'b1;
      E1: begin
        case (op)
          OP_ISZ:  mdin <= mdout + 1'b1;
          OP_JMS:  mdin <= pc;  // already points past the JMS
          default: mdin <= ac;
        endcase
      end
      H1: mdin <= cmd.data;
      default: ;
    endcase
  end

  assign mem_wdata = mdin;
  assign mem_we    = write_en;

  assign mau = '{instruction: instruction, ma: ma, mdout: mdout, isz_skip: isz_skip};

  // writes land one state after they are set up
  a_write_state: assert property (@(posedge clk) disable iff (reset)
    mem_we |-> state inside {DW1, E2, H2});

endmodule

`default_nettype wire

//--- logic/core_memory.sv
`default_nettype none

module core_memory #(
  parameter int MEM_DEPTH = 4096
) (
  input  logic            clk,
  input  pdp8_pkg::word_t addr,
  input  pdp8_pkg::word_t wdata,
  input  logic            we,
  output pdp8_pkg::word_t rdata
);
  import pdp8_pkg::*;

  localparam int AW = $clog2(MEM_DEPTH);

  word_t          mem [MEM_DEPTH];
  logic [AW-1:0]  idx;

  // low address bits only when the memory is smaller than 4K
  assign idx = addr[$bits(word_t)-AW +: AW];

  always_ff @(posedge clk) begin
    if (we) mem[idx] <= wdata;
    rdata <= mem[idx];  // old word on a write cycle
  end

endmodule

`default_nettype wire

//--- logic/retire_tracer.sv
`default_nettype none

module retire_tracer (
  input  logic                  clk,
  input  logic                  reset,
  input  host_bus_pkg::retire_t rec_in,
  input  logic                  rec_push,
  output logic                  full,
  output host_bus_pkg::retire_t rec,
  output logic                  rec_valid,
  input  logic                  rec_ready
);

  always_ff @(posedge clk) begin
    if (reset) begin
      rec_valid <= 1'b0;
    end else if (rec_push) begin
      rec_valid <= 1'b1;
    end else if (rec_ready) begin
      rec_valid <= 1'b0;  // consumer took it
    end
  end

  always_ff @(posedge clk) begin
    if (rec_push) rec <= rec_in;
  end

  assign full = rec_valid;  // single entry

  a_hold_stable: assert property (@(posedge clk) disable iff (reset)
    rec_valid && !rec_ready |=> rec_valid && $stable(rec));

endmodule

`default_nettype wire

//--- logic/pdp8_mem_top.sv
`default_nettype none

module pdp8_mem_top #(
  parameter int WORD_W    = 12,
  parameter int MEM_DEPTH = 4096
) (
  input  logic                  clk,
  input  logic                  reset,
  input  host_bus_pkg::wb_req_t wb_req,
  output host_bus_pkg::wb_rsp_t wb_rsp,
  output host_bus_pkg::retire_t rec,
  output logic                  rec_valid,
  input  logic                  rec_ready
);
  import pdp8_pkg::*;
  import host_bus_pkg::*;

  panel_cmd_t   cmd;
  logic         cmd_valid;
  logic         cmd_done;
  word_t        panel_data;
  logic         running;
  logic         link;
  word_t        ac;
  word_t        pc;
  major_state_e state;
  mau_out_t     mau;
  word_t        mem_addr;
  word_t        mem_wdata;
  logic         mem_we;
  word_t        mem_rdata;
  retire_t      seq_rec;
  logic         rec_push;
  logic         full;

  wb_host_port #(.WORD_W(WORD_W)) u_host (
    .clk, .reset, .wb_req, .wb_rsp, .running, .link, .ac,
    .cmd, .cmd_valid, .cmd_done, .panel_data
  );

  major_state_seq #(.WORD_W(WORD_W)) u_seq (
    .clk, .reset, .cmd, .cmd_valid, .cmd_done, .panel_data, .mau,
    .state, .pc, .ac, .link, .running, .rec(seq_rec), .rec_push, .full
  );

  mem_address_unit #(.WORD_W(WORD_W)) u_mau (
    .clk, .reset, .state, .pc, .ac, .cmd, .mau,
    .mem_addr, .mem_wdata, .mem_we, .mem_rdata
  );

  core_memory #(.MEM_DEPTH(MEM_DEPTH)) u_mem (
    .clk, .addr(mem_addr), .wdata(mem_wdata), .we(mem_we), .rdata(mem_rdata)
  );

  retire_tracer u_trace (
    .clk, .reset, .rec_in(seq_rec), .rec_push, .full, .rec, .rec_valid, .rec_ready
  );

endmodule

`default_nettype wire

//--- verification/tb_pdp8_mem.sv
`default_nettype none

module tb_pdp8_mem;
  import pdp8_pkg::*;
  import host_bus_pkg::*;

  localparam int PROG_WORDS     = 64;   // all programs together
  localparam int PANEL_OPS      = 200;
  localparam int TIMEOUT_CYCLES = PROG_WORDS * 12 + PANEL_OPS * 10;

  logic     clk = 1'b0;
  logic     reset;
  wb_req_t  wb_req;
  wb_rsp_t  wb_rsp;
  retire_t  rec;
  logic     rec_valid;
  logic     rec_ready = 1'b0;

  logic        ready_random = 1'b0;
  logic [31:0] ready_lcg = 32'ha3b3_b89d;
  int          cycle_count = 0;
  int          error_count = 0;

  // reference machine state
  word_t   m_mem [4096];
  word_t   m_pc;
  word_t   m_ac;
  logic    m_link;
  word_t   m_ma;
  retire_t exp_q[$];
  retire_t got_q[$];

  pdp8_mem_top #(.WORD_W(WORD_W), .MEM_DEPTH(4096)) dut_i (
    .clk, .reset, .wb_req, .wb_rsp, .rec, .rec_valid, .rec_ready
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // record sink with steady or lcg-driven ready
  always @(posedge clk) begin
    if (rec_valid && rec_ready) got_q.push_back(rec);
    if (ready_random) begin
      ready_lcg = lcg_next(ready_lcg);
      rec_ready <= ready_lcg[16];
    end else begin
      rec_ready <= 1'b1;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the DUT stopped answering", cycle_count);
      stop_run();
    end
  end

  task automatic stop_run();
    error_count++;
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %o expected %o", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_wb(input string name, input wb_rsp_t got, input wb_rsp_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_retire(input string name, input retire_t got, input retire_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  // encode a memory-reference instruction on the page of its target
  function automatic word_t mri(input opcode_e op, input logic ind, input word_t target);
    word_t w;
    w[0:2]  = op;
    w[3]    = ind;
    w[4]    = (target[0:4] != 5'b0);
    w[5:11] = target[5:11];
    return w;
  endfunction

  function automatic wb_rsp_t status_expect();
    return '{ack: 1'b1, dat: {1'b0, 2'b00, m_link, m_ac}};
  endfunction

  task automatic wb_xfer(input logic we, input logic [1:0] adr, input logic [15:0] dat,
                         output wb_rsp_t rsp);
    @(posedge clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    do begin
      @(posedge clk);
    end while (!wb_rsp.ack);
    rsp = wb_rsp;
    wb_req <= '0;
  endtask

  task automatic wb_write(input logic [1:0] adr, input logic [15:0] dat);
    wb_rsp_t rsp;
    wb_xfer(1'b1, adr, dat, rsp);
  endtask

  task automatic wb_read(input logic [1:0] adr, output wb_rsp_t rsp);
    wb_xfer(1'b0, adr, 16'h0, rsp);
  endtask

  task automatic load_addr(input word_t a);
    wb_write(REG_MA, 16'(a));
    m_ma = a;
  endtask

  task automatic deposit_word(input word_t w);
    wb_write(REG_MD, 16'(w));
    m_mem[m_ma] = w;
    m_ma = m_ma + 1'b1;
  endtask

  task automatic deposit_block(input word_t start, input word_t words[$]);
    int i;
    load_addr(start);
    for (i = 0; i < words.size(); i++) deposit_word(words[i]);
  endtask

  task automatic examine_range(input word_t start, input int n);
    wb_rsp_t rsp;
    word_t   got;
    int      i;
    load_addr(start);
    for (i = 0; i < n; i++) begin
      wb_read(REG_MD, rsp);
      got = rsp.dat[11:0];
      check_word($sformatf("memory %o", m_ma), got, m_mem[m_ma]);
      m_ma = m_ma + 1'b1;
    end
  endtask

  // one instruction of the software machine
  task automatic step_reference(output retire_t r);
    word_t   ir;
    word_t   here;
    word_t   addr;
    word_t   ptr;
    word_t   opnd;
    word_t   md;
    opcode_e op;
    here = m_pc;
    ir   = m_mem[here];
    op   = opcode_e'(ir[0:2]);
    md   = ir;
    m_pc = here + 1'b1;
    if (op == OP_OPR) begin
      if (!ir[3]) begin  // group 1 only
        if (ir[4]) m_ac = '0;
        if (ir[6]) m_ac = ~m_ac;
        if (ir[11]) {m_link, m_ac} = {m_link, m_ac} + 13'd1;
      end
    end else if (op != OP_IOT) begin
      addr = {(ir[4] ? here[0:4] : 5'b0), ir[5:11]};
      if (ir[3]) begin
        ptr = m_mem[addr];
        md  = ptr;
        if (addr >= 12'o0010 && addr <= 12'o0017) begin
          ptr = ptr + 1'b1;
          m_mem[addr] = ptr;
        end
        addr = ptr;
      end
      m_ma = addr;
      if (op == OP_JMP) begin
        m_pc = addr;
      end else begin
        opnd = m_mem[addr];
        md   = opnd;
        case (op)
          OP_AND: m_ac = m_ac & opnd;
          OP_TAD: {m_link, m_ac} = {m_link, m_ac} + {1'b0, opnd};
          OP_ISZ: begin
            opnd = opnd + 1'b1;
            m_mem[addr] = opnd;
            if (opnd == 12'o0000) m_pc = m_pc + 1'b1;
          end
          OP_DCA: begin
            m_mem[addr] = m_ac;
            m_ac = '0;
          end
          default: begin  // jms
            m_mem[addr] = m_pc;
            m_pc = addr + 1'b1;
          end
        endcase
      end
    end
    r = '{pc: here, instruction: ir, ac: m_ac, link: m_link, ma: m_ma, mdout: md};
  endtask

  task automatic run_reference(input word_t start);
    retire_t r;
    logic    done;
    int      n;
    m_pc = start;
    exp_q.delete();
    done = 1'b0;
    n = 0;
    while (!done) begin
      step_reference(r);
      exp_q.push_back(r);
      done = (r.instruction == HLT_WORD);
      n++;
      if (n > 500) begin
        $display("reference program at %o never reached HLT", start);
        stop_run();
      end
    end
  endtask

  task automatic run_program(input word_t start, input logic poke_while_running);
    wb_rsp_t rsp;
    logic    halted;
    int      i;
    run_reference(start);
    got_q.delete();
    wb_write(REG_RUN, 16'(start));
    if (poke_while_running) begin
      wb_read(REG_STATUS, rsp);
      if (!rsp.dat[STATUS_RUN_BIT]) begin
        $display("processor was not running during the locked-out panel accesses");
        stop_run();
      end
      wb_write(REG_MA, 16'o0705);
      wb_write(REG_MD, 16'o5555);
      wb_read(REG_MD, rsp);
      check_wb("md read while running", rsp, '{ack: 1'b1, dat: 16'h0000});
      wb_write(REG_RUN, 16'o0200);
    end
    halted = 1'b0;
    while (!halted) begin
      @(negedge clk);
      if (got_q.size() != 0) halted = (got_q[got_q.size()-1].instruction == HLT_WORD);
    end
    if (got_q.size() != exp_q.size()) begin
      $display("got %0d retire records, expected %0d", got_q.size(), exp_q.size());
      stop_run();
    end
    for (i = 0; i < exp_q.size(); i++) begin
      check_retire($sformatf("rec[%0d]", i), got_q[i], exp_q[i]);
    end
    wb_read(REG_STATUS, rsp);
    check_wb("status after halt", rsp, status_expect());
  endtask

  task automatic panel_round_trip();
    wb_rsp_t     rsp;
    logic [31:0] seed;
    int          i;
    seed = 32'ha3b3_b89d;
    if (rec_valid !== 1'b0) begin
      $display("rec_valid is not low after reset");
      stop_run();
    end
    wb_read(REG_STATUS, rsp);
    check_wb("status after reset", rsp, '{ack: 1'b1, dat: 16'h0000});
    load_addr(12'o0500);
    for (i = 0; i < 6; i++) begin
      seed = lcg_next(seed);
      deposit_word(seed[27:16]);
    end
    examine_range(12'o0500, 6);
  endtask

  task automatic direct_program();
    word_t prog[$];
    prog = {12'o7200, mri(OP_TAD, 1'b0, 12'o0040), mri(OP_TAD, 1'b0, 12'o0270),
            mri(OP_AND, 1'b0, 12'o0041), mri(OP_DCA, 1'b0, 12'o0042), 12'o7040, 12'o7001,
            mri(OP_TAD, 1'b0, 12'o0041), 12'o7241, mri(OP_TAD, 1'b0, 12'o0270),
            mri(OP_DCA, 1'b0, 12'o0271), 12'o7001, mri(OP_TAD, 1'b0, 12'o0040),
            12'o6001, HLT_WORD};
    deposit_block(12'o0200, prog);
    deposit_block(12'o0040, {12'o0123, 12'o7707, 12'o0000});
    deposit_block(12'o0270, {12'o0055, 12'o0000});
    run_program(12'o0200, 1'b0);
    examine_range(12'o0040, 3);
    examine_range(12'o0270, 2);
  endtask

  task automatic indirect_program();
    word_t prog[$];
    prog = {12'o7200, mri(OP_TAD, 1'b1, 12'o0050), mri(OP_DCA, 1'b1, 12'o0051),
            mri(OP_TAD, 1'b1, 12'o0010), mri(OP_DCA, 1'b1, 12'o0011),
            mri(OP_TAD, 1'b1, 12'o0010), mri(OP_DCA, 1'b1, 12'o0011),
            mri(OP_TAD, 1'b1, 12'o0010), mri(OP_TAD, 1'b1, 12'o0050),
            mri(OP_DCA, 1'b1, 12'o0011), HLT_WORD};
    deposit_block(12'o0300, prog);
    deposit_block(12'o0010, {12'o0417, 12'o0437});  // auto-index pointers
    deposit_block(12'o0050, {12'o0400, 12'o0401});
    deposit_block(12'o0400, {12'o0012, 12'o0000});
    deposit_block(12'o0420, {12'o0111, 12'o0222, 12'o0333});
    deposit_block(12'o0440, {12'o0000, 12'o0000, 12'o0000});
    run_program(12'o0300, 1'b0);
    examine_range(12'o0010, 2);
    examine_range(12'o0050, 2);
    examine_range(12'o0400, 2);
    examine_range(12'o0440, 3);
  endtask

  task automatic skip_and_subroutine();
    word_t prog[$];
    prog = {12'o7200, mri(OP_ISZ, 1'b0, 12'o0060), 12'o7001, mri(OP_ISZ, 1'b0, 12'o0061),
            12'o7001, mri(OP_JMS, 1'b0, 12'o0640), 12'o7001, mri(OP_JMP, 1'b0, 12'o0612),
            12'o7001, 12'o7001, mri(OP_JMS, 1'b0, 12'o0640), mri(OP_JMP, 1'b1, 12'o0062),
            12'o7001, HLT_WORD};
    deposit_block(12'o0600, prog);
    deposit_block(12'o0060, {12'o7777, 12'o0005, 12'o0615});
    deposit_block(12'o0640, {12'o0000, mri(OP_TAD, 1'b0, 12'o0061),
                             mri(OP_JMP, 1'b1, 12'o0640)});
    run_program(12'o0600, 1'b0);
    examine_range(12'o0060, 3);
    examine_range(12'o0640, 1);
  endtask

  task automatic backpressure_program();
    word_t prog[$];
    prog = {12'o7200, 12'o7001, 12'o7001, 12'o6000, 12'o7040, mri(OP_TAD, 1'b0, 12'o0770),
            12'o7001, mri(OP_DCA, 1'b0, 12'o0771), 12'o6000, mri(OP_TAD, 1'b0, 12'o0771),
            12'o7041, 12'o7001, 12'o6000, 12'o7200, 12'o7001, 12'o7040,
            mri(OP_TAD, 1'b0, 12'o0040), mri(OP_AND, 1'b0, 12'o0770), 12'o7001, 12'o6000,
            12'o7001, mri(OP_DCA, 1'b0, 12'o0072), 12'o7001, HLT_WORD};
    deposit_block(12'o0700, prog);
    deposit_block(12'o0770, {12'o0321, 12'o0000});
    deposit_block(12'o0072, {12'o0000});
    ready_random <= 1'b1;
    run_program(12'o0700, 1'b1);
    ready_random <= 1'b0;
    examine_range(12'o0700, 24);  // the ignored deposit aimed at 0705
    examine_range(12'o0770, 2);
    examine_range(12'o0072, 1);
  endtask

  initial begin
    reset  = 1'b1;
    wb_req = '0;
    m_pc   = '0;
    m_ac   = '0;
    m_link = 1'b0;
    m_ma   = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    panel_round_trip();
    direct_program();
    indirect_program();
    skip_and_subroutine();
    backpressure_program();
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
logic/pdp8_pkg.sv
logic/host_bus_pkg.sv
logic/wb_host_port.sv
logic/major_state_seq.sv
logic/mem_address_unit.sv
logic/core_memory.sv
logic/retire_tracer.sv
logic/pdp8_mem_top.sv
verification/tb_pdp8_mem.sv
